//--- rvPkg.sv
package rvPkg;

    // Data and address words
    typedef logic [31:0] wordT;
    typedef logic [4:0]  regAddrT;
    typedef logic [3:0]  aluOpT;

    typedef enum logic [1:0] {
        sFetch,
        sDecode,
        sExecute,
        sWriteback
    } ctrlStateT;

    // Arithmetic and logic codes
    localparam aluOpT aluAdd  = 4'b0000;
    localparam aluOpT aluSub  = 4'b1000;
    localparam aluOpT aluSll  = 4'b0001;
    localparam aluOpT aluSlt  = 4'b0010;
    localparam aluOpT aluSltu = 4'b0011;
    localparam aluOpT aluXor  = 4'b0100;
    localparam aluOpT aluSrl  = 4'b0101;
    localparam aluOpT aluSra  = 4'b1101;
    localparam aluOpT aluOr   = 4'b0110;
    localparam aluOpT aluAnd  = 4'b0111;

    // Branch compare codes
    localparam aluOpT aluBeq  = 4'b1001;
    localparam aluOpT aluBne  = 4'b1010;
    localparam aluOpT aluBlt  = 4'b1011;
    localparam aluOpT aluBge  = 4'b1100;
    localparam aluOpT aluBltu = 4'b1110;
    localparam aluOpT aluBgeu = 4'b1111;

    // Major opcodes handled by the core
    localparam logic [6:0] opcOp     = 7'b0110011;
    localparam logic [6:0] opcOpImm  = 7'b0010011;
    localparam logic [6:0] opcBranch = 7'b1100011;
    localparam logic [6:0] opcLui    = 7'b0110111;

    localparam wordT resetPc = 32'h0000_0000;
    localparam wordT pcStep  = 32'd4;

endpackage

//--- execIf.sv
`timescale 1ns/1ns

interface execIf;
    import rvPkg::*;

    // Operands and operation from the decoder
    wordT    opA;
    wordT    opB;
    aluOpT   aluOp;
    logic    isBranch;
    logic    writeEn;
    regAddrT rd;

    // Registered execute outputs
    wordT    result;
    logic    takeBranch;

    modport decode (
        output opA, opB, aluOp, isBranch, writeEn, rd
    );

    modport alu (
        input  opA, opB, aluOp,
        output result, takeBranch
    );

    modport ctrl (
        input isBranch, writeEn, rd, result, takeBranch
    );

endinterface

//--- aluCore.sv
`timescale 1ns/1ns

module aluCore (
    input  logic clk,
    input  logic rstN,
    input  logic exEn,
    execIf.alu   ex
);
    import rvPkg::*;

    wordT       aluOut;
    logic       branchHit;
    logic       signedLt;
    logic       unsignedLt;
    logic [4:0] shamt;

    assign shamt      = ex.opB[4:0];
    assign signedLt   = $signed(ex.opA) < $signed(ex.opB);
    assign unsignedLt = ex.opA < ex.opB;

    always_comb begin
        aluOut    = '0;
        branchHit = 1'b0;
        case (ex.aluOp)
            aluAdd:  aluOut = ex.opA + ex.opB;
            aluSub:  aluOut = ex.opA - ex.opB;
            aluSll:  aluOut = ex.opA << shamt;
            aluSlt:  aluOut = {31'b0, signedLt};
            aluSltu: aluOut = {31'b0, unsignedLt};
            aluXor:  aluOut = ex.opA ^ ex.opB;
            aluSrl:  aluOut = ex.opA >> shamt;
            // Sign bit must fill from the left
            aluSra:  aluOut = wordT'($signed(ex.opA) >>> shamt);
            aluOr:   aluOut = ex.opA | ex.opB;
            aluAnd:  aluOut = ex.opA & ex.opB;
            // Compares only since the target is built in the PC unit
            aluBeq:  branchHit = ex.opA == ex.opB;
            aluBne:  branchHit = ex.opA != ex.opB;
            aluBlt:  branchHit = signedLt;
            aluBge:  branchHit = !signedLt;
            aluBltu: branchHit = unsignedLt;
            aluBgeu: branchHit = !unsignedLt;
            default: begin
                aluOut    = '0;
                branchHit = 1'b0;
            end
        endcase
    end

    // Result held from execute through writeback
    always_ff @(posedge clk) begin
        if (exEn) begin
            ex.result <= aluOut;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ex.takeBranch <= 1'b0;
        end else if (exEn) begin
            ex.takeBranch <= branchHit;
        end
    end

endmodule

//--- regFile.sv
`timescale 1ns/1ns

module regFile (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::regAddrT rs1,
    input  rvPkg::regAddrT rs2,
    input  logic           wbEn,
    input  rvPkg::regAddrT rd,
    input  rvPkg::wordT    wrData,
    output rvPkg::wordT    rs1Data,
    output rvPkg::wordT    rs2Data
);
    import rvPkg::*;

    // x0 has no storage
    wordT regs [1:31];

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            for (int i = 1; i < 32; i++) begin
                regs[i] <= '0;
            end
        end else if (wbEn && (rd != '0)) begin
            regs[rd] <= wrData;
        end
    end

    // Index zero always reads back as zero
    always_comb begin
        if (rs1 == '0) begin
            rs1Data = '0;
        end else begin
            rs1Data = regs[rs1];
        end
    end

    always_comb begin
        if (rs2 == '0) begin
            rs2Data = '0;
        end else begin
            rs2Data = regs[rs2];
        end
    end

endmodule

//--- instrDecode.sv
`timescale 1ns/1ns

module instrDecode (
    input  logic           clk,
    input  logic           rstN,
    input  logic           fetchEn,
    input  logic           decEn,
    input  rvPkg::wordT    instr,
    input  rvPkg::wordT    rs1Data,
    input  rvPkg::wordT    rs2Data,
    output rvPkg::regAddrT rs1,
    output rvPkg::regAddrT rs2,
    output rvPkg::wordT    branchOff,
    execIf.decode          ex
);
    import rvPkg::*;

    wordT       instrReg;
    logic [6:0] opcode;
    logic [2:0] funct3;
    logic       funct7b5;
    regAddrT    rdField;
    wordT       immI;
    wordT       immB;
    wordT       immU;

    wordT       nextOpA;
    wordT       nextOpB;
    aluOpT      nextAluOp;
    logic       nextIsBranch;
    logic       nextWriteEn;

    always_ff @(posedge clk) begin
        if (fetchEn) begin
            instrReg <= instr;
        end
    end

    // Instruction fields
    assign opcode   = instrReg[6:0];
    assign rdField  = instrReg[11:7];
    assign funct3   = instrReg[14:12];
    assign rs1      = instrReg[19:15];
    assign rs2      = instrReg[24:20];
    assign funct7b5 = instrReg[30];

    assign immI = {{20{instrReg[31]}}, instrReg[31:20]};
    assign immB = {{19{instrReg[31]}}, instrReg[31], instrReg[7],
                   instrReg[30:25], instrReg[11:8], 1'b0};
    assign immU = {instrReg[31:12], 12'b0};

    always_comb begin
        nextOpA      = rs1Data;
        nextOpB      = rs2Data;
        nextAluOp    = aluAdd;
        nextIsBranch = 1'b0;
        nextWriteEn  = 1'b0;
        case (opcode)
            opcOp: begin
                // funct7 bit 5 selects SUB and SRA
                nextAluOp   = {funct7b5 & (funct3 == 3'b000 || funct3 == 3'b101), funct3};
                nextWriteEn = rdField != '0;
            end
            opcOpImm: begin
                nextOpB     = immI;
                nextAluOp   = {funct7b5 & (funct3 == 3'b101), funct3};
                nextWriteEn = rdField != '0;
            end
            opcBranch: begin
                nextIsBranch = 1'b1;
                case (funct3)
                    3'b000:  nextAluOp = aluBeq;
                    3'b001:  nextAluOp = aluBne;
                    3'b100:  nextAluOp = aluBlt;
                    3'b101:  nextAluOp = aluBge;
                    3'b110:  nextAluOp = aluBltu;
                    3'b111:  nextAluOp = aluBgeu;
                    default: nextAluOp = aluAdd;
                endcase
            end
            opcLui: begin
                nextOpA     = '0;
                nextOpB     = immU;
                nextWriteEn = rdField != '0;
            end
            default: begin
                nextWriteEn = 1'b0;
            end
        endcase
    end

    always_ff @(posedge clk) begin
        if (decEn) begin
            ex.opA    <= nextOpA;
            ex.opB    <= nextOpB;
            ex.rd     <= rdField;
            branchOff <= immB;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            ex.aluOp    <= aluAdd;
            ex.isBranch <= 1'b0;
            ex.writeEn  <= 1'b0;
        end else if (decEn) begin
            ex.aluOp    <= nextAluOp;
            ex.isBranch <= nextIsBranch;
            ex.writeEn  <= nextWriteEn;
        end
    end

endmodule

//--- coreCtrl.sv
`timescale 1ns/1ns

module coreCtrl (
    input  logic           clk,
    input  logic           rstN,
    execIf.ctrl            ex,
    output logic           fetchEn,
    output logic           decEn,
    output logic           exEn,
    output logic           wbEn,
    output logic           pcAdvance,
    output logic           retireValid,
    output rvPkg::regAddrT retireRd,
    output rvPkg::wordT    retireData
);
    import rvPkg::*;

    ctrlStateT state;
    ctrlStateT nextState;
    logic      inWriteback;

    // Fixed four-phase cycle with no stalls
    always_comb begin
        case (state)
            sFetch:     nextState = sDecode;
            sDecode:    nextState = sExecute;
            sExecute:   nextState = sWriteback;
            sWriteback: nextState = sFetch;
            default:    nextState = sFetch;
        endcase
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            state <= sFetch;
        end else begin
            state <= nextState;
        end
    end

    assign inWriteback = state == sWriteback;

    // One strobe per phase
    assign fetchEn   = state == sFetch;
    assign decEn     = state == sDecode;
    assign exEn      = state == sExecute;
    assign pcAdvance = inWriteback;

    // Register write only when the instruction has a destination
    assign wbEn = inWriteback && ex.writeEn;

    assign retireValid = inWriteback;

    always_comb begin
        if (ex.writeEn) begin
            retireRd   = ex.rd;
            retireData = ex.result;
        end else begin
            retireRd   = '0;
            retireData = '0;
        end
    end

endmodule

//--- pcUnit.sv
`timescale 1ns/1ns

module pcUnit (
    input  logic        clk,
    input  logic        rstN,
    input  logic        pcAdvance,
    input  logic        takeBranch,
    input  rvPkg::wordT branchOff,
    output rvPkg::wordT pc,
    output rvPkg::wordT nextPc
);
    import rvPkg::*;

    // Branch target is PC relative
    always_comb begin
        if (takeBranch) begin
            nextPc = pc + branchOff;
        end else begin
            nextPc = pc + pcStep;
        end
    end

    always_ff @(posedge clk or negedge rstN) begin
        if (!rstN) begin
            pc <= resetPc;
        end else if (pcAdvance) begin
            pc <= nextPc;
        end
    end

endmodule

//--- rvCore.sv
`timescale 1ns/1ns

module rvCore (
    input  logic           clk,
    input  logic           rstN,
    input  rvPkg::wordT    instr,
    output rvPkg::wordT    instrAddr,
    output logic           retireValid,
    output rvPkg::wordT    retirePc,
    output rvPkg::regAddrT retireRd,
    output rvPkg::wordT    retireData,
    output rvPkg::wordT    retireNextPc
);
    import rvPkg::*;

    execIf ex ();

    regAddrT rs1;
    regAddrT rs2;
    wordT    rs1Data;
    wordT    rs2Data;
    wordT    branchOff;
    wordT    pc;
    logic    fetchEn;
    logic    decEn;
    logic    exEn;
    logic    wbEn;
    logic    pcAdvance;
    logic    branchTaken;

    // Redirect only on a real branch instruction
    assign branchTaken = ex.isBranch && ex.takeBranch;

    assign instrAddr = pc;
    assign retirePc  = pc;

    instrDecode uDecode (
        .clk       (clk),
        .rstN      (rstN),
        .fetchEn   (fetchEn),
        .decEn     (decEn),
        .instr     (instr),
        .rs1Data   (rs1Data),
        .rs2Data   (rs2Data),
        .rs1       (rs1),
        .rs2       (rs2),
        .branchOff (branchOff),
        .ex        (ex.decode)
    );

    regFile uRegs (
        .clk     (clk),
        .rstN    (rstN),
        .rs1     (rs1),
        .rs2     (rs2),
        .wbEn    (wbEn),
        .rd      (ex.rd),
        .wrData  (ex.result),
        .rs1Data (rs1Data),
        .rs2Data (rs2Data)
    );

    aluCore uAlu (
        .clk  (clk),
        .rstN (rstN),
        .exEn (exEn),
        .ex   (ex.alu)
    );

    coreCtrl uCtrl (
        .clk         (clk),
        .rstN        (rstN),
        .ex          (ex.ctrl),
        .fetchEn     (fetchEn),
        .decEn       (decEn),
        .exEn        (exEn),
        .wbEn        (wbEn),
        .pcAdvance   (pcAdvance),
        .retireValid (retireValid),
        .retireRd    (retireRd),
        .retireData  (retireData)
    );

    pcUnit uPc (
        .clk        (clk),
        .rstN       (rstN),
        .pcAdvance  (pcAdvance),
        .takeBranch (branchTaken),
        .branchOff  (branchOff),
        .pc         (pc),
        .nextPc     (retireNextPc)
    );

endmodule

//--- tbIss.svh
`ifndef TB_ISS_SVH
`define TB_ISS_SVH

// Random source state
wordT rngState = 32'h6ab1_0cf1;

// Model architectural state
wordT modelRegs [32];
wordT modelPc;

function automatic wordT nextRand();
    rngState = rngState ^ (rngState << 13);
    rngState = rngState ^ (rngState >> 17);
    rngState = rngState ^ (rngState << 5);
    return rngState;
endfunction

// Kind 0 is register ALU, 1 immediate ALU, 2 branch mix and 3 x0 heavy
function automatic wordT genInstr(input int kind);
    wordT        r;
    wordT        s;
    logic [2:0]  f3;
    regAddrT     rd;
    logic [12:0] off;
    r = nextRand();
    s = nextRand();
    f3 = s[2:0];
    // Registers x0..x7 so that operands collide often
    rd = (kind == 3 && r[31]) ? 5'd0 : {2'b0, s[5:3]};
    if (kind == 2 && r[30]) begin
        // Map the two reserved branch codes onto BLTU and BGEU
        if (f3[2:1] == 2'b01) begin
            f3[2] = 1'b1;
        end
        off = {{5{s[13]}}, s[13:8], 2'b00};
        return {off[12], off[10:5], 2'b0, s[17:15], 2'b0, s[20:18], f3,
                off[4:1], off[11], opcBranch};
    end
    if (r[3:0] < 4'd3) begin
        // Seed a register with a wide value
        if (r[4]) begin
            return {s[31:12], rd, opcLui};
        end
        return {s[31:20], 5'd0, 3'b000, rd, opcOpImm};
    end
    if (kind == 0 || (kind != 1 && r[5])) begin
        return {1'b0, r[6] & (f3 == 3'b000 || f3 == 3'b101), 5'b0, 2'b0, s[17:15],
                2'b0, s[20:18], f3, rd, opcOp};
    end
    if (f3 == 3'b001 || f3 == 3'b101) begin
        return {1'b0, r[6] & f3[2], 5'b0, s[29:25], 2'b0, s[20:18], f3, rd, opcOpImm};
    end
    return {r[27:16], 2'b0, s[20:18], f3, rd, opcOpImm};
endfunction

function automatic wordT aluModel(input logic [2:0] f3, input logic alt,
                                  input wordT a, input wordT b);
    case (f3)
        3'b000:  return alt ? a - b : a + b;
        3'b001:  return a << b[4:0];
        3'b010:  return {31'b0, $signed(a) < $signed(b)};
        3'b011:  return {31'b0, a < b};
        3'b100:  return a ^ b;
        3'b101:  return alt ? wordT'($signed(a) >>> b[4:0]) : a >> b[4:0];
        3'b110:  return a | b;
        default: return a & b;
    endcase
endfunction

function automatic logic branchModel(input logic [2:0] f3, input wordT a, input wordT b);
    case (f3)
        3'b000:  return a == b;
        3'b001:  return a != b;
        3'b100:  return $signed(a) < $signed(b);
        3'b101:  return $signed(a) >= $signed(b);
        3'b110:  return a < b;
        default: return a >= b;
    endcase
endfunction

// Execute one instruction on the model state
task automatic issStep(input wordT ins, output regAddrT rd, output wordT data,
                       output wordT npc);
    wordT a;
    wordT b;
    wordT immI;
    wordT immB;
    a = modelRegs[ins[19:15]];
    b = modelRegs[ins[24:20]];
    immI = {{20{ins[31]}}, ins[31:20]};
    immB = {{20{ins[31]}}, ins[7], ins[30:25], ins[11:8], 1'b0};
    rd = ins[11:7];
    data = '0;
    npc = modelPc + 32'd4;
    case (ins[6:0])
        opcOp:    data = aluModel(ins[14:12], ins[30], a, b);
        opcOpImm: data = aluModel(ins[14:12], ins[30] && ins[14:12] == 3'b101, a, immI);
        opcLui:   data = {ins[31:12], 12'b0};
        opcBranch: begin
            rd = '0;
            if (branchModel(ins[14:12], a, b)) begin
                npc = modelPc + immB;
            end
        end
        default:  rd = '0;
    endcase
    // x0 keeps its zero
    if (rd == '0) begin
        data = '0;
    end
    modelRegs[rd] = data;
    modelPc = npc;
endtask

`endif

//--- tbRvCore.sv
`timescale 1ns/1ns

module tbRvCore;
    import rvPkg::*;

    localparam int resetCycles  = 8;
    localparam int totalRetires = 8 + 200 + 200 + 200 + 100;
    localparam int cycleLimit   = totalRetires * 4 + 100;

    logic    clk = 1'b0;
    logic    rstN;
    wordT    instr;
    wordT    instrAddr;
    logic    retireValid;
    wordT    retirePc;
    regAddrT retireRd;
    wordT    retireData;
    wordT    retireNextPc;

    wordT    imem [64];
    int      cycles = 0;
    int      errors = 0;
    int      passed = 0;

    `include "tbIss.svh"

    rvCore dut (
        .clk          (clk),
        .rstN         (rstN),
        .instr        (instr),
        .instrAddr    (instrAddr),
        .retireValid  (retireValid),
        .retirePc     (retirePc),
        .retireRd     (retireRd),
        .retireData   (retireData),
        .retireNextPc (retireNextPc)
    );

    always #20 clk = ~clk;

    // Address wraps inside the 64 word window
    assign instr = imem[instrAddr[7:2]];

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles > cycleLimit) begin
            $display("Timeout after %0d cycles, retire pulses stopped arriving", cycles);
            $display("Test FAILED");
            $finish;
        end
    end

    task automatic checkWord(input string name, input wordT got, input wordT exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %h expected %h", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkReg(input string name, input regAddrT got, input regAddrT exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %0d expected %0d", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic checkBit(input string name, input logic got, input logic exp);
        if (got !== exp) begin
            $display("FAIL %0t %s got %b expected %b", $time, name, got, exp);
            errors++;
        end
    endtask

    task automatic applyReset();
        @(posedge clk);
        rstN <= 1'b0;
        repeat (resetCycles) begin
            @(negedge clk);
            checkBit("retireValid", retireValid, 1'b0);
            @(posedge clk);
        end
        rstN <= 1'b1;
        for (int i = 0; i < 32; i++) begin
            modelRegs[i] = '0;
        end
        modelPc = '0;
    endtask

    task automatic runTest(input string name, input int kind, input int count);
        regAddrT expRd;
        wordT    expData;
        wordT    expNext;
        int      errorsBefore;
        int      gap;
        int      retired;
        errorsBefore = errors;
        for (int i = 0; i < 64; i++) begin
            imem[i] = genInstr(kind);
        end
        applyReset();
        gap = 0;
        retired = 0;
        while (retired < count) begin
            @(negedge clk);
            gap++;
            if (retireValid) begin
                // First retire 4 cycles after release and every 4 after that
                if (gap != 4) begin
                    $display("%0t: retire came %0d cycles after the previous one, not 4",
                             $time, gap);
                    errors++;
                end
                checkWord("retirePc", retirePc, modelPc);
                checkWord("instrAddr", instrAddr, modelPc);
                issStep(imem[modelPc[7:2]], expRd, expData, expNext);
                checkReg("retireRd", retireRd, expRd);
                checkWord("retireData", retireData, expData);
                checkWord("retireNextPc", retireNextPc, expNext);
                gap = 0;
                retired++;
            end
        end
        if (errors == errorsBefore) begin
            passed++;
        end
        $display("%s: %0d retires, %0d errors", name, retired, errors - errorsBefore);
    endtask

    initial begin
        rstN <= 1'b0;
        runTest("reset", 0, 8);
        runTest("register ALU", 0, 200);
        runTest("immediate ALU and LUI", 1, 200);
        runTest("branches", 2, 200);
        runTest("register x0", 3, 100);
        $display("%0d of 5 tests passed, %0d errors", passed, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

endmodule

//--- verilog.f
+incdir+.
rvPkg.sv
execIf.sv
aluCore.sv
regFile.sv
instrDecode.sv
coreCtrl.sv
pcUnit.sv
rvCore.sv
tbRvCore.sv

//--- run.sh
#!/bin/sh
# Build and run the core testbench with Verilator
set -e
cd "$(dirname "$0")"
verilator --binary --timing --top-module tbRvCore -f verilog.f -o simRvCore
./obj_dir/simRvCore > sim.log
cat sim.log
if grep -q "^Test OK$" sim.log; then
    exit 0
fi
exit 1
